// File: src/xmem_pkg.sv
`default_nettype none

package xmem_pkg;

    // data path is fixed at four byte lanes
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // access size decoded from the byte enables
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // exception code returned with the handshake
    typedef enum logic [1:0] {
        EXC_NONE         = 2'b00,
        EXC_MISALIGNED   = 2'b01, // be pattern not in legal set
        EXC_ACCESS_FAULT = 2'b10  // tag bits not zero
    } exc_e;

    // bank control state
    typedef enum logic {
        BANK_INIT  = 1'b0, // clearing words after reset
        BANK_READY = 1'b1
    } bank_state_e;

endpackage

`default_nettype wire

// File: src/cvxif_dcache_adapter.sv
`timescale 1ns/1ns
`default_nettype none

module cvxif_dcache_adapter #(
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 4,
    parameter int unsigned NUM_BANKS  = 4,
    parameter int unsigned BANK_DEPTH = 16
) (
    input  wire logic                              clk_i,  // interface shape only
    input  wire logic                              rst_ni, // interface shape only
    input  wire logic                              x_mem_valid_i,
    input  wire logic [ADDR_WIDTH-1:0]             x_mem_addr_i,
    input  wire logic                              x_mem_we_i,
    input  wire logic [xmem_pkg::BE_WIDTH-1:0]     x_mem_be_i,
    input  wire logic [xmem_pkg::DATA_WIDTH-1:0]   x_mem_wdata_i,
    input  wire logic [ID_WIDTH-1:0]               x_mem_id_i,
    input  wire logic                              bank_gnt_i,
    output logic                                   x_mem_ready_o,
    output logic                                   x_mem_exc_o,
    output xmem_pkg::exc_e                         x_mem_exccode_o,
    output logic                                   req_valid_o,
    output logic [$clog2(NUM_BANKS)-1:0]           req_bank_o,
    output logic [$clog2(BANK_DEPTH)-1:0]          req_index_o,
    output logic                                   req_we_o,
    output logic [xmem_pkg::BE_WIDTH-1:0]          req_be_o,
    output logic [xmem_pkg::DATA_WIDTH-1:0]        req_wdata_o,
    output logic [ID_WIDTH-1:0]                    req_id_o,
    output xmem_pkg::size_e                        req_size_o
);
    import xmem_pkg::*;

    localparam int unsigned BANK_W  = $clog2(NUM_BANKS);
    localparam int unsigned INDEX_W = $clog2(BANK_DEPTH);
    localparam int unsigned BANK_LSB  = 2; // bits 1:0 are the byte offset
    localparam int unsigned INDEX_LSB = BANK_LSB + BANK_W;
    localparam int unsigned TAG_LSB   = INDEX_LSB + INDEX_W;

    logic  tag_err;
    logic  be_legal;
    exc_e  exc_code;

    assign tag_err = |x_mem_addr_i[ADDR_WIDTH-1:TAG_LSB]; // no tags stored, only tag 0 maps

    // be pattern to size, anything else is misaligned
    always_comb begin
        be_legal   = 1'b1;
        req_size_o = SIZE_WORD;
        case (x_mem_be_i)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: req_size_o = SIZE_BYTE;
            4'b0011, 4'b1100:                   req_size_o = SIZE_HALF;
            4'b1111:                            req_size_o = SIZE_WORD;
            default: begin
                be_legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (tag_err) begin
            exc_code = EXC_ACCESS_FAULT; // wins over a bad be
        end else if (!be_legal) begin
            exc_code = EXC_MISALIGNED;
        end else begin
            exc_code = EXC_NONE;
        end
    end

    assign x_mem_ready_o   = bank_gnt_i; // low while any bank initialises
    assign x_mem_exc_o     = x_mem_valid_i && (exc_code != EXC_NONE);
    assign x_mem_exccode_o = exc_code;

    // forward only clean transfers
    assign req_valid_o = x_mem_valid_i && bank_gnt_i && (exc_code == EXC_NONE);
    assign req_bank_o  = x_mem_addr_i[INDEX_LSB-1:BANK_LSB];
    assign req_index_o = x_mem_addr_i[TAG_LSB-1:INDEX_LSB];
    assign req_we_o    = x_mem_we_i;
    assign req_be_o    = x_mem_be_i;
    assign req_wdata_o = x_mem_wdata_i;
    assign req_id_o    = x_mem_id_i;

endmodule

`default_nettype wire

// File: src/dcache_bank_router.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_bank_router #(
    parameter int unsigned NUM_BANKS = 4
) (
    input  wire logic                         req_valid_i,
    input  wire logic [$clog2(NUM_BANKS)-1:0] req_bank_i,
    input  wire logic [NUM_BANKS-1:0]         bank_ready_i,
    output logic      [NUM_BANKS-1:0]         bank_req_valid_o,
    output logic                              bank_gnt_o
);

    localparam int unsigned BANK_W = $clog2(NUM_BANKS);

    logic [NUM_BANKS-1:0] bank_sel;

    // one-hot bank decode
    always_comb begin
        bank_sel = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (req_bank_i == BANK_W'(b)) begin
                bank_sel[b] = 1'b1;
            end
        end
    end

    // at most one bank sees a valid request
    assign bank_req_valid_o = req_valid_i ? bank_sel : '0;

    // accept only once every bank has finished its clear
    assign bank_gnt_o = &bank_ready_i;

endmodule

`default_nettype wire

// File: src/dcache_bank.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_bank #(
    parameter int unsigned BANK_DEPTH = 16,
    parameter int unsigned ID_WIDTH   = 4
) (
    input  wire logic                             clk_i,
    input  wire logic                             rst_ni,
    input  wire logic                             req_valid_i,
    input  wire logic [$clog2(BANK_DEPTH)-1:0]    req_index_i,
    input  wire logic                             req_we_i,
    input  wire logic [xmem_pkg::BE_WIDTH-1:0]    req_be_i,
    input  wire logic [xmem_pkg::DATA_WIDTH-1:0]  req_wdata_i,
    input  wire logic [ID_WIDTH-1:0]              req_id_i,
    output logic                                  ready_o,
    output logic                                  rsp_valid_o,
    output logic      [xmem_pkg::DATA_WIDTH-1:0]  rsp_rdata_o,
    output logic      [ID_WIDTH-1:0]              rsp_id_o
);
    import xmem_pkg::*;

    localparam int unsigned INDEX_W = $clog2(BANK_DEPTH);

    logic [DATA_WIDTH-1:0] mem_q [BANK_DEPTH];
    bank_state_e           state_q;
    logic [INDEX_W-1:0]    init_cnt_q;

    // clear one word per cycle, then serve requests
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= BANK_INIT;
            init_cnt_q  <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i && (state_q == BANK_READY);
            if (state_q == BANK_INIT) begin
                init_cnt_q <= init_cnt_q + 1'b1;
                if (init_cnt_q == INDEX_W'(BANK_DEPTH - 1)) begin
                    state_q <= BANK_READY; // last word cleared
                end
            end
        end
    end

    // storage and read register
    always_ff @(posedge clk_i) begin
        if (state_q == BANK_INIT) begin
            mem_q[init_cnt_q] <= '0;
        end else if (req_valid_i) begin
            if (req_we_i) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (req_be_i[b]) begin
                        mem_q[req_index_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                end
            end
            rsp_rdata_o <= req_we_i ? '0 : mem_q[req_index_i]; // writes return zero
            rsp_id_o    <= req_id_i;
        end
    end

    assign ready_o = (state_q == BANK_READY);

endmodule

`default_nettype wire

// File: src/dcache_rsp_merge.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_rsp_merge #(
    parameter int unsigned NUM_BANKS = 4,
    parameter int unsigned ID_WIDTH  = 4
) (
    input  wire logic                                            clk_i,
    input  wire logic                                            rst_ni,
    input  wire logic [NUM_BANKS-1:0]                            rsp_valid_i,
    input  wire logic [NUM_BANKS-1:0][xmem_pkg::DATA_WIDTH-1:0]  rsp_rdata_i,
    input  wire logic [NUM_BANKS-1:0][ID_WIDTH-1:0]              rsp_id_i,
    output logic                                                 x_mem_result_valid_o,
    output logic      [ID_WIDTH-1:0]                             x_mem_result_id_o,
    output logic      [xmem_pkg::DATA_WIDTH-1:0]                 x_mem_result_rdata_o,
    output logic                                                 x_mem_result_err_o
);
    import xmem_pkg::*;

    logic                  any_valid;
    logic [DATA_WIDTH-1:0] sel_rdata;
    logic [ID_WIDTH-1:0]   sel_id;

    // and-or select, banks never respond together
    always_comb begin
        sel_rdata = '0;
        sel_id    = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            sel_rdata = sel_rdata | (rsp_rdata_i[b] & {DATA_WIDTH{rsp_valid_i[b]}});
            sel_id    = sel_id | (rsp_id_i[b] & {ID_WIDTH{rsp_valid_i[b]}});
        end
    end

    assign any_valid = |rsp_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            x_mem_result_valid_o <= 1'b0;
            x_mem_result_err_o   <= 1'b0;
        end else begin
            x_mem_result_valid_o <= any_valid;
            x_mem_result_err_o   <= 1'b0; // no error source behind the banks
        end
    end

    always_ff @(posedge clk_i) begin
        x_mem_result_id_o    <= sel_id;
        x_mem_result_rdata_o <= sel_rdata;
    end

endmodule

`default_nettype wire

// File: src/xmem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module xmem_subsystem #(
    parameter int unsigned NUM_BANKS  = 4,
    parameter int unsigned BANK_DEPTH = 16,
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 4
) (
    input  wire logic                             clk_i,
    input  wire logic                             rst_ni,
    input  wire logic                             x_mem_valid_i,
    input  wire logic [ADDR_WIDTH-1:0]            x_mem_addr_i,
    input  wire logic                             x_mem_we_i,
    input  wire logic [xmem_pkg::BE_WIDTH-1:0]    x_mem_be_i,
    input  wire logic [xmem_pkg::DATA_WIDTH-1:0]  x_mem_wdata_i,
    input  wire logic [ID_WIDTH-1:0]              x_mem_id_i,
    output logic                                  x_mem_ready_o,
    output logic                                  x_mem_exc_o,
    output xmem_pkg::exc_e                        x_mem_exccode_o,
    output logic                                  x_mem_result_valid_o,
    output logic      [ID_WIDTH-1:0]              x_mem_result_id_o,
    output logic      [xmem_pkg::DATA_WIDTH-1:0]  x_mem_result_rdata_o,
    output logic                                  x_mem_result_err_o
);
    import xmem_pkg::*;

    localparam int unsigned BANK_W  = $clog2(NUM_BANKS);
    localparam int unsigned INDEX_W = $clog2(BANK_DEPTH);

    // adapter to router and banks
    logic                  req_valid;
    logic [BANK_W-1:0]     req_bank;
    logic [INDEX_W-1:0]    req_index;
    logic                  req_we;
    logic [BE_WIDTH-1:0]   req_be;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic [ID_WIDTH-1:0]   req_id;
    logic                  bank_gnt;

    // per bank
    logic [NUM_BANKS-1:0]                 bank_req_valid;
    logic [NUM_BANKS-1:0]                 bank_ready;
    logic [NUM_BANKS-1:0]                 rsp_valid;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] rsp_rdata;
    logic [NUM_BANKS-1:0][ID_WIDTH-1:0]   rsp_id;

    cvxif_dcache_adapter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_adapter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .x_mem_valid_i   (x_mem_valid_i),
        .x_mem_addr_i    (x_mem_addr_i),
        .x_mem_we_i      (x_mem_we_i),
        .x_mem_be_i      (x_mem_be_i),
        .x_mem_wdata_i   (x_mem_wdata_i),
        .x_mem_id_i      (x_mem_id_i),
        .bank_gnt_i      (bank_gnt),
        .x_mem_ready_o   (x_mem_ready_o),
        .x_mem_exc_o     (x_mem_exc_o),
        .x_mem_exccode_o (x_mem_exccode_o),
        .req_valid_o     (req_valid),
        .req_bank_o      (req_bank),
        .req_index_o     (req_index),
        .req_we_o        (req_we),
        .req_be_o        (req_be),
        .req_wdata_o     (req_wdata),
        .req_id_o        (req_id),
        .req_size_o      ()
    );

    dcache_bank_router #(
        .NUM_BANKS (NUM_BANKS)
    ) u_router (
        .req_valid_i      (req_valid),
        .req_bank_i       (req_bank),
        .bank_ready_i     (bank_ready),
        .bank_req_valid_o (bank_req_valid),
        .bank_gnt_o       (bank_gnt)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dcache_bank #(
            .BANK_DEPTH (BANK_DEPTH),
            .ID_WIDTH   (ID_WIDTH)
        ) u_bank (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .req_valid_i (bank_req_valid[b]),
            .req_index_i (req_index),
            .req_we_i    (req_we),
            .req_be_i    (req_be),
            .req_wdata_i (req_wdata),
            .req_id_i    (req_id),
            .ready_o     (bank_ready[b]),
            .rsp_valid_o (rsp_valid[b]),
            .rsp_rdata_o (rsp_rdata[b]),
            .rsp_id_o    (rsp_id[b])
        );
    end

    dcache_rsp_merge #(
        .NUM_BANKS (NUM_BANKS),
        .ID_WIDTH  (ID_WIDTH)
    ) u_merge (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .rsp_valid_i          (rsp_valid),
        .rsp_rdata_i          (rsp_rdata),
        .rsp_id_i             (rsp_id),
        .x_mem_result_valid_o (x_mem_result_valid_o),
        .x_mem_result_id_o    (x_mem_result_id_o),
        .x_mem_result_rdata_o (x_mem_result_rdata_o),
        .x_mem_result_err_o   (x_mem_result_err_o)
    );

endmodule

`default_nettype wire

// File: test/tb_xmem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_xmem_subsystem;
    import xmem_pkg::*;

    localparam int NUM_BANKS  = 4;
    localparam int BANK_DEPTH = 16;
    localparam int ADDR_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_WORDS  = NUM_BANKS * BANK_DEPTH;
    localparam int TAG_LSB    = 2 + $clog2(NUM_BANKS) + $clog2(BANK_DEPTH);
    localparam int B2B_COUNT  = 40;
    localparam int WAIT_LIMIT = 4 * BANK_DEPTH; // ready or drain wait, in cycles
    // init reads, word and byte tests, exceptions, back to back, plus drains
    localparam int TXN_CYCLES = NUM_WORDS + 16 + 18 + 7 + B2B_COUNT + 5 * 4;
    localparam int WATCHDOG_CYCLES = 2 * (2 + BANK_DEPTH + TXN_CYCLES);

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  x_mem_valid_i;
    logic [ADDR_WIDTH-1:0] x_mem_addr_i;
    logic                  x_mem_we_i;
    logic [BE_WIDTH-1:0]   x_mem_be_i;
    logic [DATA_WIDTH-1:0] x_mem_wdata_i;
    logic [ID_WIDTH-1:0]   x_mem_id_i;
    logic                  x_mem_ready_o;
    logic                  x_mem_exc_o;
    exc_e                  x_mem_exccode_o;
    logic                  x_mem_result_valid_o;
    logic [ID_WIDTH-1:0]   x_mem_result_id_o;
    logic [DATA_WIDTH-1:0] x_mem_result_rdata_o;
    logic                  x_mem_result_err_o;

    int                    seed = 32'h07f3_f52f;
    int                    cycle = 0; // rising edges seen so far
    int                    pass_cnt = 0;
    int                    fail_cnt = 0;
    int                    test_fail_start;
    string                 cur_test;
    logic [ID_WIDTH-1:0]   next_id = '0;
    logic [DATA_WIDTH-1:0] model [int]; // word index to data, absent means zero
    logic [ID_WIDTH-1:0]   exp_id_q [$];
    logic [DATA_WIDTH-1:0] exp_data_q [$];
    int                    exp_cyc_q [$];

    xmem_subsystem #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_dut (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .x_mem_valid_i        (x_mem_valid_i),
        .x_mem_addr_i         (x_mem_addr_i),
        .x_mem_we_i           (x_mem_we_i),
        .x_mem_be_i           (x_mem_be_i),
        .x_mem_wdata_i        (x_mem_wdata_i),
        .x_mem_id_i           (x_mem_id_i),
        .x_mem_ready_o        (x_mem_ready_o),
        .x_mem_exc_o          (x_mem_exc_o),
        .x_mem_exccode_o      (x_mem_exccode_o),
        .x_mem_result_valid_o (x_mem_result_valid_o),
        .x_mem_result_id_o    (x_mem_result_id_o),
        .x_mem_result_rdata_o (x_mem_result_rdata_o),
        .x_mem_result_err_o   (x_mem_result_err_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        fail_cnt++;
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] exp, input logic [DATA_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: data expected %h actual %h", cur_test, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_id(input logic [ID_WIDTH-1:0] exp, input logic [ID_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: id expected %0d actual %0d", cur_test, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_exc(input exc_e exp, input exc_e act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: exc expected %s actual %s", cur_test, exp.name(), act.name());
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // exception rules of the request check, tag fault first
    function automatic exc_e expected_exc(input logic [ADDR_WIDTH-1:0] addr,
                                          input logic [BE_WIDTH-1:0] be);
        if ((addr >> TAG_LSB) != '0) return EXC_ACCESS_FAULT;
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111: return EXC_NONE;
            default: return EXC_MISALIGNED;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_read(input logic [ADDR_WIDTH-1:0] addr);
        int key;
        key = int'(addr[TAG_LSB-1:2]);
        return model.exists(key) ? model[key] : '0;
    endfunction

    task automatic model_write(input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                               input logic [DATA_WIDTH-1:0] wdata);
        logic [DATA_WIDTH-1:0] word;
        word = model_read(addr);
        for (int b = 0; b < BE_WIDTH; b++) begin
            if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
        end
        model[int'(addr[TAG_LSB-1:2])] = word;
    endtask

    // called just after a rising edge, returns just after the accept edge
    task automatic issue(input logic [ADDR_WIDTH-1:0] addr, input logic we,
                         input logic [BE_WIDTH-1:0] be, input logic [DATA_WIDTH-1:0] wdata);
        exc_e exp_exc;
        exc_e got_exc;
        int   waited;
        exp_exc = expected_exc(addr, be);
        x_mem_valid_i = 1'b1;
        x_mem_addr_i  = addr;
        x_mem_we_i    = we;
        x_mem_be_i    = be;
        x_mem_wdata_i = wdata;
        x_mem_id_i    = next_id;
        waited = 0;
        @(negedge clk_i);
        while (!x_mem_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!x_mem_ready_o) begin
            report_error("request never accepted, ready stayed low");
        end else begin
            if (waited != 0) begin
                report_error("request stalled, ready was low after initialisation");
            end
            got_exc = x_mem_exc_o ? x_mem_exccode_o : EXC_NONE;
            check_exc(exp_exc, got_exc);
            if (exp_exc == EXC_NONE) begin
                exp_id_q.push_back(next_id);
                exp_data_q.push_back(we ? '0 : model_read(addr)); // writes return zero
                exp_cyc_q.push_back(cycle + 2); // second edge from here, accept edge included
                if (we) model_write(addr, be, wdata);
            end
            next_id++;
        end
        @(posedge clk_i);
        #1;
        x_mem_valid_i = 1'b0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_id_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (exp_id_q.size() != 0) begin
            report_error($sformatf("%0d results never arrived", exp_id_q.size()));
            exp_id_q.delete();
            exp_data_q.delete();
            exp_cyc_q.delete();
        end
        @(posedge clk_i); // one idle cycle to catch stray results
        #1;
    endtask

    // result port monitor, sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_ni && x_mem_result_valid_o) begin
            if (exp_id_q.size() == 0) begin
                report_error("result arrived with no request outstanding");
            end else begin
                check_id(exp_id_q.pop_front(), x_mem_result_id_o);
                check_data(exp_data_q.pop_front(), x_mem_result_rdata_o);
                if (exp_cyc_q[0] != cycle) begin
                    report_error($sformatf("result due at cycle %0d came at cycle %0d",
                                           exp_cyc_q[0], cycle));
                end
                void'(exp_cyc_q.pop_front());
                if (x_mem_result_err_o !== 1'b0) report_error("result error flag set");
            end
        end
    end

    task automatic start_test(input string name);
        cur_test = name;
        test_fail_start = fail_cnt;
    endtask

    task automatic finish_test();
        $display("%-18s done, %0d mismatches", cur_test, fail_cnt - test_fail_start);
    endtask

    task automatic test_init();
        int low_cycles;
        start_test("test_init");
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        low_cycles = 0;
        @(negedge clk_i);
        while (!x_mem_ready_o && low_cycles < WAIT_LIMIT) begin
            low_cycles++;
            @(negedge clk_i);
        end
        check_data(BANK_DEPTH, low_cycles); // one cleared word per cycle
        @(posedge clk_i);
        #1;
        for (int w = 0; w < NUM_WORDS; w++) begin
            issue(w << 2, 1'b0, 4'b1111, '0);
        end
        drain_results();
        finish_test();
    endtask

    task automatic test_word_rw();
        start_test("test_word_rw");
        for (int i = 0; i < 8; i++) begin
            issue(((i * 5 + 1) % NUM_WORDS) << 2, 1'b1, 4'b1111, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue(((i * 5 + 1) % NUM_WORDS) << 2, 1'b0, 4'b1111, '0);
        end
        drain_results();
        finish_test();
    endtask

    task automatic test_byte_half();
        logic [BE_WIDTH-1:0] pat [6];
        int                  word;
        pat = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
        start_test("test_byte_half");
        for (int i = 0; i < 6; i++) begin
            word = (i * 9 + 3) % NUM_WORDS;
            issue(word << 2, 1'b1, 4'b1111, $random(seed));
            issue(word << 2, 1'b1, pat[i], $random(seed));
            issue(word << 2, 1'b0, 4'b1111, '0);
        end
        drain_results();
        finish_test();
    endtask

    task automatic test_exceptions();
        logic [ADDR_WIDTH-1:0] addr;
        addr = 32'h0000_0014;
        start_test("test_exceptions");
        issue(addr, 1'b1, 4'b0101, $random(seed));
        issue(addr, 1'b1, 4'b1110, $random(seed));
        issue(addr, 1'b1, 4'b0000, $random(seed));
        issue(addr | (32'h1 << TAG_LSB), 1'b1, 4'b1111, $random(seed));
        issue(addr | 32'h8000_0000, 1'b1, 4'b0110, $random(seed)); // fault beats misaligned
        issue(addr | (32'h1 << TAG_LSB), 1'b0, 4'b1111, '0);
        drain_results();
        issue(addr, 1'b0, 4'b1111, '0);
        drain_results();
        finish_test();
    endtask

    task automatic test_back_to_back();
        logic [BE_WIDTH-1:0] legal_be [7];
        int                  word;
        logic                we;
        logic [BE_WIDTH-1:0] be;
        legal_be = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        start_test("test_back_to_back");
        for (int i = 0; i < B2B_COUNT; i++) begin
            word = $unsigned($random(seed)) % NUM_WORDS;
            we   = $random(seed);
            be   = legal_be[$unsigned($random(seed)) % 7];
            issue(word << 2, we, be, $random(seed));
        end
        drain_results();
        finish_test();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_ni        = 1'b0;
        x_mem_valid_i = 1'b0;
        x_mem_addr_i  = '0;
        x_mem_we_i    = 1'b0;
        x_mem_be_i    = '0;
        x_mem_wdata_i = '0;
        x_mem_id_i    = '0;
        test_init();
        test_word_rw();
        test_byte_half();
        test_exceptions();
        test_back_to_back();
        $display("summary: %0d checks ok, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/xmem_pkg.sv
src/cvxif_dcache_adapter.sv
src/dcache_bank_router.sv
src/dcache_bank.sv
src/dcache_rsp_merge.sv
src/xmem_subsystem.sv
test/tb_xmem_subsystem.sv
